//--- src/rv_mem_pkg.sv
`default_nettype none

package rv_mem_pkg;

    localparam int XLEN = 64;

    // Memory operation carried from EX into MA.
    typedef enum logic [3:0] {
        op_none     = 4'd0,  // ALU result passes through.
        op_load     = 4'd1,
        op_store    = 4'd2,
        op_lr       = 4'd3,
        op_sc       = 4'd4,
        op_amo_swap = 4'd5,
        op_amo_add  = 4'd6,
        op_amo_xor  = 4'd7,
        op_amo_or   = 4'd8,
        op_amo_and  = 4'd9,
        op_amo_min  = 4'd10,
        op_amo_max  = 4'd11,
        op_amo_minu = 4'd12,
        op_amo_maxu = 4'd13
    } mem_op_e;

    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2,
        size_d = 2'd3
    } mem_size_e;

    // Trap cause codes, mcause numbering.
    localparam logic [4:0] cause_none             = 5'd0;
    localparam logic [4:0] cause_load_misaligned  = 5'd4;
    localparam logic [4:0] cause_store_misaligned = 5'd6;

    function automatic logic is_amo_op(mem_op_e op);
        return op inside {op_amo_swap, op_amo_add, op_amo_xor, op_amo_or,
                          op_amo_and, op_amo_min, op_amo_max, op_amo_minu,
                          op_amo_maxu};
    endfunction

endpackage

`default_nettype wire

//--- src/stage_ex_ma.sv
`timescale 1ns/1ns
`default_nettype none

module stage_ex_ma import rv_mem_pkg::*; #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  stall,
    input  logic                  trap_en,

    input  logic [ADDR_WIDTH-1:0] pc_in,
    input  logic [4:0]            rd_in,
    input  logic [XLEN-1:0]       result_in,
    input  logic [XLEN-1:0]       data2_in,
    input  mem_op_e               op_in,
    input  mem_size_e             size_in,
    input  logic                  unsigned_in,
    input  logic [4:0]            cause_in,

    output logic [ADDR_WIDTH-1:0] pc_out,
    output logic [4:0]            rd_out,
    output logic [XLEN-1:0]       result_out,
    output logic [XLEN-1:0]       data2_out,
    output mem_op_e               op_out,
    output mem_size_e             size_out,
    output logic                  unsigned_out,
    output logic [4:0]            cause_out
);

    logic flush;

    // A trap in MA kills the incoming instruction, but only once MA moves on.
    assign flush = clear | (trap_en & ~stall);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            pc_out       <= '0;
            rd_out       <= '0;
            result_out   <= '0;
            data2_out    <= '0;
            op_out       <= op_none;  // Bubble.
            size_out     <= size_b;
            unsigned_out <= 1'b0;
            cause_out    <= cause_none;
        end else if (!stall) begin
            pc_out       <= pc_in;
            rd_out       <= rd_in;
            result_out   <= result_in;
            data2_out    <= data2_in;
            op_out       <= op_in;
            size_out     <= size_in;
            unsigned_out <= unsigned_in;
            cause_out    <= cause_in;
        end
    end

endmodule

`default_nettype wire

//--- src/mem_access.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access import rv_mem_pkg::*; #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,

    input  logic [ADDR_WIDTH-1:0] pc,
    input  logic [4:0]            rd,
    input  logic [XLEN-1:0]       addr,
    input  logic [XLEN-1:0]       data2,
    input  mem_op_e               op,
    input  mem_size_e             size,
    input  logic                  is_unsigned,
    input  logic [4:0]            cause,
    input  logic [XLEN-1:0]       ram_rdata,

    output logic                  trap_en,
    output logic [ADDR_WIDTH-1:3] ram_addr,
    output logic [XLEN-1:0]       ram_wdata,
    output logic [7:0]            ram_wmask,
    output logic                  ram_we,

    output logic                  wb_valid,
    output logic [4:0]            wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  trap_valid,
    output logic [4:0]            trap_cause,
    output logic [ADDR_WIDTH-1:0] trap_pc,
    output logic [XLEN-1:0]       trap_tval
);

    logic                  is_amo;
    logic                  is_atomic;
    logic                  is_write_class;
    logic                  addr_unaligned;
    logic                  misaligned;
    logic [4:0]            trap_code;
    logic [5:0]            shift;
    logic [7:0]            size_mask;
    logic [XLEN-1:0]       lane;
    logic                  load_unsigned;
    logic [XLEN-1:0]       load_val;
    logic                  amo_unsigned;
    logic [XLEN-1:0]       amo_a;
    logic [XLEN-1:0]       amo_b;
    logic [XLEN-1:0]       amo_new;
    logic [XLEN-1:0]       store_val;
    logic                  sc_ok;
    logic                  do_write;
    logic                  wb_req;
    logic [XLEN-1:0]       wb_val;
    logic                  resv_valid;
    logic [ADDR_WIDTH-1:0] resv_addr;
    logic                  commit;

    assign is_amo         = is_amo_op(op);
    assign is_atomic      = is_amo || op == op_lr || op == op_sc;
    assign is_write_class = is_amo || op == op_store || op == op_sc;

    always_comb begin
        unique case (size)
            size_b: begin
                size_mask      = 8'h01;
                addr_unaligned = 1'b0;
            end
            size_h: begin
                size_mask      = 8'h03;
                addr_unaligned = addr[0];
            end
            size_w: begin
                size_mask      = 8'h0f;
                addr_unaligned = |addr[1:0];
            end
            default: begin
                size_mask      = 8'hff;
                addr_unaligned = |addr[2:0];
            end
        endcase
    end

    // Atomics exist only as .W and .D.
    assign misaligned = (op != op_none) &&
                        (addr_unaligned || (is_atomic && (size == size_b || size == size_h)));

    assign trap_en   = (cause != cause_none) || misaligned;
    assign trap_code = (cause != cause_none) ? cause :
                       is_write_class ? cause_store_misaligned : cause_load_misaligned;

    // Move the addressed bytes down to lane 0.
    assign shift = {addr[2:0], 3'b000};
    assign lane  = ram_rdata >> shift;

    assign load_unsigned = is_unsigned && (op == op_load);  // LR and AMO always sign-extend.

    always_comb begin
        unique case (size)
            size_b:  load_val = load_unsigned ? {56'b0, lane[7:0]}  : {{56{lane[7]}}, lane[7:0]};
            size_h:  load_val = load_unsigned ? {48'b0, lane[15:0]} : {{48{lane[15]}}, lane[15:0]};
            size_w:  load_val = load_unsigned ? {32'b0, lane[31:0]} : {{32{lane[31]}}, lane[31:0]};
            default: load_val = lane;
        endcase
    end

    // Word operands are widened so 64-bit compares give word results.
    assign amo_unsigned = (op == op_amo_minu) || (op == op_amo_maxu);

    always_comb begin
        if (size == size_w) begin
            amo_a = amo_unsigned ? {32'b0, lane[31:0]}  : {{32{lane[31]}}, lane[31:0]};
            amo_b = amo_unsigned ? {32'b0, data2[31:0]} : {{32{data2[31]}}, data2[31:0]};
        end else begin
            amo_a = lane;
            amo_b = data2;
        end
    end

    always_comb begin
        case (op)
            op_amo_add:  amo_new = amo_a + amo_b;
            op_amo_xor:  amo_new = amo_a ^ amo_b;
            op_amo_or:   amo_new = amo_a | amo_b;
            op_amo_and:  amo_new = amo_a & amo_b;
            op_amo_min:  amo_new = ($signed(amo_a) < $signed(amo_b)) ? amo_a : amo_b;
            op_amo_max:  amo_new = ($signed(amo_a) > $signed(amo_b)) ? amo_a : amo_b;
            op_amo_minu: amo_new = (amo_a < amo_b) ? amo_a : amo_b;
            op_amo_maxu: amo_new = (amo_a > amo_b) ? amo_a : amo_b;
            default:     amo_new = amo_b;  // Swap.
        endcase
    end

    assign store_val = is_amo ? amo_new : data2;

    assign sc_ok    = resv_valid && (resv_addr == addr[ADDR_WIDTH-1:0]);
    assign do_write = (op == op_store) || is_amo || ((op == op_sc) && sc_ok);
    assign commit   = !stall && !trap_en;

    assign ram_addr  = addr[ADDR_WIDTH-1:3];
    assign ram_wdata = store_val << shift;
    assign ram_wmask = size_mask << addr[2:0];
    assign ram_we    = do_write && commit;

    // Writes to x0 are dropped.
    assign wb_req = (rd != 5'd0) && (op != op_store);

    always_comb begin
        if (op == op_none) begin
            wb_val = addr;
        end else if (op == op_sc) begin
            wb_val = sc_ok ? '0 : {{(XLEN-1){1'b0}}, 1'b1};
        end else begin
            wb_val = load_val;  // Loads, LR and the old AMO value.
        end
    end

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            wb_valid   <= 1'b0;
            trap_valid <= 1'b0;
        end else begin
            wb_valid   <= wb_req && !trap_en;
            trap_valid <= trap_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_rd      <= rd;
            wb_data    <= wb_val;
            trap_cause <= trap_code;
            trap_pc    <= pc;
            trap_tval  <= (cause == cause_none) ? addr : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resv_valid <= 1'b0;
        end else if (commit) begin
            if (op == op_lr) begin
                resv_valid <= 1'b1;
            end else if (op == op_sc) begin
                resv_valid <= 1'b0;
            end else if ((op == op_store || is_amo) &&
                         addr[ADDR_WIDTH-1:3] == resv_addr[ADDR_WIDTH-1:3]) begin
                resv_valid <= 1'b0;  // Reserved doubleword was written.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit && op == op_lr) begin
            resv_addr <= addr[ADDR_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

//--- src/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram import rv_mem_pkg::*; #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:3] addr,
    input  logic [XLEN-1:0]       wdata,
    input  logic [7:0]            wmask,
    input  logic                  we,
    output logic [XLEN-1:0]       rdata
);

    localparam int DEPTH = 2 ** (ADDR_WIDTH - 3);

    logic [XLEN-1:0] mem [DEPTH];

    // Power-up contents.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 8; b++) begin
                if (wmask[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata = mem[addr];  // Asynchronous read.

endmodule

`default_nettype wire

//--- src/mem_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_top import rv_mem_pkg::*; #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  clear,

    input  logic [ADDR_WIDTH-1:0] pc_in,
    input  logic [4:0]            rd_in,
    input  logic [XLEN-1:0]       result_in,
    input  logic [XLEN-1:0]       data2_in,
    input  mem_op_e               op_in,
    input  mem_size_e             size_in,
    input  logic                  unsigned_in,
    input  logic [4:0]            cause_in,

    output logic                  wb_valid,
    output logic [4:0]            wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  trap_valid,
    output logic [4:0]            trap_cause,
    output logic [ADDR_WIDTH-1:0] trap_pc,
    output logic [XLEN-1:0]       trap_tval
);

    // Instruction held in MA.
    logic [ADDR_WIDTH-1:0] ma_pc;
    logic [4:0]            ma_rd;
    logic [XLEN-1:0]       ma_result;
    logic [XLEN-1:0]       ma_data2;
    mem_op_e               ma_op;
    mem_size_e             ma_size;
    logic                  ma_unsigned;
    logic [4:0]            ma_cause;
    logic                  trap_en;

    logic [ADDR_WIDTH-1:3] ram_addr;
    logic [XLEN-1:0]       ram_wdata;
    logic [7:0]            ram_wmask;
    logic                  ram_we;
    logic [XLEN-1:0]       ram_rdata;

    stage_ex_ma #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_stage_ex_ma (
        .clk          (clk),
        .reset        (reset),
        .clear        (clear),
        .stall        (stall),
        .trap_en      (trap_en),
        .pc_in        (pc_in),
        .rd_in        (rd_in),
        .result_in    (result_in),
        .data2_in     (data2_in),
        .op_in        (op_in),
        .size_in      (size_in),
        .unsigned_in  (unsigned_in),
        .cause_in     (cause_in),
        .pc_out       (ma_pc),
        .rd_out       (ma_rd),
        .result_out   (ma_result),
        .data2_out    (ma_data2),
        .op_out       (ma_op),
        .size_out     (ma_size),
        .unsigned_out (ma_unsigned),
        .cause_out    (ma_cause)
    );

    mem_access #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem_access (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .pc          (ma_pc),
        .rd          (ma_rd),
        .addr        (ma_result),  // Effective address for memory ops.
        .data2       (ma_data2),
        .op          (ma_op),
        .size        (ma_size),
        .is_unsigned (ma_unsigned),
        .cause       (ma_cause),
        .ram_rdata   (ram_rdata),
        .trap_en     (trap_en),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_wmask   (ram_wmask),
        .ram_we      (ram_we),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .trap_valid  (trap_valid),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .trap_tval   (trap_tval)
    );

    data_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_data_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .wmask (ram_wmask),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- tb/mem_subsystem_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_assertions (
    input wire logic clk,
    input wire logic reset,
    input wire logic stall,
    input wire logic ram_we,
    input wire logic wb_valid,
    input wire logic trap_valid
);

    // One result kind per cycle.
    assert property (@(posedge clk) disable iff (reset) !(wb_valid && trap_valid))
        else $error("wb_valid and trap_valid high together");

    assert property (@(posedge clk) stall |-> !ram_we)
        else $error("RAM write during stall");

    assert property (@(posedge clk) reset |=> (!wb_valid && !trap_valid))
        else $error("Output valid in the cycle after reset");

endmodule

bind mem_subsystem_top mem_subsystem_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .ram_we     (ram_we),
    .wb_valid   (wb_valid),
    .trap_valid (trap_valid)
);

`default_nettype wire

//--- tb/tb_mem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsystem import rv_mem_pkg::*;;

    localparam int ADDR_WIDTH = 12;
    localparam int kind_wb    = 0;
    localparam int kind_trap  = 1;
    localparam int kind_none  = 2;
    localparam int kind_kill  = 3;  // Flushed by the trap ahead of it.
    localparam int kind_clear = 4;  // Flushed by clear in the following cycle.

    typedef struct {
        mem_op_e               op;
        mem_size_e             size;
        logic                  uns;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       data2;
        logic [4:0]            rd;
        logic [ADDR_WIDTH-1:0] pc;
        logic [4:0]            cause;
        int                    kind;
        logic [XLEN-1:0]       exp;  // Write-back data, or the trap cause.
        logic [XLEN-1:0]       tval;
        int                    stalls;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  stall;
    logic                  clear;
    logic [ADDR_WIDTH-1:0] pc_in;
    logic [4:0]            rd_in;
    logic [XLEN-1:0]       result_in;
    logic [XLEN-1:0]       data2_in;
    mem_op_e               op_in;
    mem_size_e             size_in;
    logic                  unsigned_in;
    logic [4:0]            cause_in;
    logic                  wb_valid;
    logic [4:0]            wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  trap_valid;
    logic [4:0]            trap_cause;
    logic [ADDR_WIDTH-1:0] trap_pc;
    logic [XLEN-1:0]       trap_tval;

    row_t        rows[$];
    row_t        expected[$];
    int          cycles;
    int          limit;
    logic [31:0] rng;

    mem_subsystem_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .clear       (clear),
        .pc_in       (pc_in),
        .rd_in       (rd_in),
        .result_in   (result_in),
        .data2_in    (data2_in),
        .op_in       (op_in),
        .size_in     (size_in),
        .unsigned_in (unsigned_in),
        .cause_in    (cause_in),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .trap_valid  (trap_valid),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .trap_tval   (trap_tval)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input mem_op_e op, input mem_size_e size, input logic uns,
                           input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data2,
                           input logic [4:0] rd, input logic [4:0] cause, input int kind,
                           input logic [XLEN-1:0] exp, input logic [XLEN-1:0] tval,
                           input int stalls);
        row_t r;
        r = '{op, size, uns, addr, data2, rd, 12'h400 + 12'(rows.size() * 4), cause,
              kind, exp, tval, stalls};
        rows.push_back(r);
    endtask

    task automatic drive_idle(input logic stall_v, input logic clear_v);
        stall       = stall_v;
        clear       = clear_v;
        pc_in       = '0;
        rd_in       = '0;
        result_in   = '0;
        data2_in    = '0;
        op_in       = op_none;
        size_in     = size_b;
        unsigned_in = 1'b0;
        cause_in    = cause_none;
    endtask

    task automatic drive_row(input row_t r);
        stall       = 1'b0;
        clear       = 1'b0;
        pc_in       = r.pc;
        rd_in       = r.rd;
        result_in   = r.addr;
        data2_in    = r.data2;
        op_in       = r.op;
        size_in     = r.size;
        unsigned_in = r.uns;
        cause_in    = r.cause;
    endtask

    task automatic build_table();
        // Byte-lane placement and extension.
        add_row(op_store, size_d, 0, 'h100, 64'h8877665544332211, 0, 0, kind_none, 0, 0, 0);
        add_row(op_load,  size_d, 0, 'h100, 0, 1, 0, kind_wb, 64'h8877665544332211, 0, 0);
        add_row(op_load,  size_b, 0, 'h107, 0, 2, 0, kind_wb, 64'hffffffffffffff88, 0, 1);
        add_row(op_load,  size_b, 1, 'h107, 0, 3, 0, kind_wb, 64'h88, 0, 0);
        add_row(op_load,  size_h, 0, 'h106, 0, 4, 0, kind_wb, 64'hffffffffffff8877, 0, 0);
        add_row(op_load,  size_h, 1, 'h106, 0, 5, 0, kind_wb, 64'h8877, 0, 0);
        add_row(op_load,  size_w, 0, 'h104, 0, 6, 0, kind_wb, 64'hffffffff88776655, 0, 0);
        add_row(op_load,  size_w, 1, 'h104, 0, 7, 0, kind_wb, 64'h88776655, 0, 0);
        add_row(op_store, size_b, 0, 'h101, 64'haa, 0, 0, kind_none, 0, 0, 0);
        add_row(op_store, size_h, 0, 'h102, 64'hbbcc, 0, 0, kind_none, 0, 0, 1);
        add_row(op_store, size_w, 0, 'h104, 64'h12345678ddeeff00, 0, 0, kind_none, 0, 0, 0);
        add_row(op_load,  size_d, 0, 'h100, 0, 8, 0, kind_wb, 64'hddeeff00bbccaa11, 0, 2);
        // Doubleword AMOs, signed and unsigned compares.
        add_row(op_store, size_d, 0, 'h200, 64'hfffffffffffffff0, 0, 0, kind_none, 0, 0, 0);
        add_row(op_amo_add,  size_d, 0, 'h200, 64'h20, 9, 0, kind_wb, 64'hfffffffffffffff0, 0, 0);
        add_row(op_load,     size_d, 0, 'h200, 0, 10, 0, kind_wb, 64'h10, 0, 0);
        add_row(op_amo_min,  size_d, 0, 'h200, 64'hfffffffffffffffb, 11, 0, kind_wb, 64'h10, 0, 0);
        add_row(op_amo_minu, size_d, 0, 'h200, 64'h7, 12, 0, kind_wb, 64'hfffffffffffffffb, 0, 2);
        add_row(op_amo_max,  size_d, 0, 'h200, 64'hffffffffffffff9c, 13, 0, kind_wb, 64'h7, 0, 0);
        add_row(op_amo_maxu, size_d, 0, 'h200, 64'hffffffffffffff9c, 14, 0, kind_wb, 64'h7, 0, 0);
        add_row(op_load,     size_d, 0, 'h200, 0, 15, 0, kind_wb, 64'hffffffffffffff9c, 0, 0);
        // Word AMOs return the sign-extended old word.
        add_row(op_store, size_d, 0, 'h208, 64'h80000000, 0, 0, kind_none, 0, 0, 0);
        add_row(op_amo_swap, size_w, 0, 'h208, 64'h11111111, 16, 0, kind_wb,
                64'hffffffff80000000, 0, 0);
        add_row(op_amo_xor, size_w, 0, 'h20c, 64'h0f0f0f0f, 17, 0, kind_wb, 64'h0, 0, 0);
        add_row(op_amo_or,  size_w, 0, 'h208, 64'h80000000, 18, 0, kind_wb, 64'h11111111, 0, 0);
        add_row(op_amo_and, size_w, 0, 'h208, 64'hf0f0f0f0, 19, 0, kind_wb,
                64'hffffffff91111111, 0, 1);
        add_row(op_amo_max, size_w, 0, 'h208, 64'h1, 20, 0, kind_wb, 64'hffffffff90101010, 0, 0);
        add_row(op_load, size_d, 0, 'h208, 0, 21, 0, kind_wb, 64'h0f0f0f0f00000001, 0, 0);
        // LR/SC reservation.
        add_row(op_lr,   size_d, 0, 'h300, 0, 22, 0, kind_wb, 64'h0, 0, 0);
        add_row(op_sc,   size_d, 0, 'h300, 64'hcafe, 23, 0, kind_wb, 64'h0, 0, 0);
        add_row(op_load, size_d, 0, 'h300, 0, 24, 0, kind_wb, 64'hcafe, 0, 0);
        add_row(op_sc,   size_d, 0, 'h300, 64'hbeef, 25, 0, kind_wb, 64'h1, 0, 0);
        add_row(op_load, size_d, 0, 'h300, 0, 26, 0, kind_wb, 64'hcafe, 0, 0);
        add_row(op_lr,   size_w, 0, 'h304, 0, 27, 0, kind_wb, 64'h0, 0, 0);
        add_row(op_store, size_b, 0, 'h300, 64'h55, 0, 0, kind_none, 0, 0, 0);
        add_row(op_sc,   size_w, 0, 'h304, 64'h1234, 28, 0, kind_wb, 64'h1, 0, 1);
        add_row(op_load, size_d, 0, 'h300, 0, 29, 0, kind_wb, 64'hca55, 0, 0);
        // Misaligned accesses kill the row behind them.
        add_row(op_load,  size_w, 0, 'h102, 0, 30, 0, kind_trap, 4, 'h102, 0);
        add_row(op_store, size_d, 0, 'h300, 64'hdead, 0, 0, kind_kill, 0, 0, 0);
        add_row(op_store, size_h, 0, 'h101, 64'h77, 0, 0, kind_trap, 6, 'h101, 0);
        add_row(op_store, size_d, 0, 'h300, 64'hdead, 0, 0, kind_kill, 0, 0, 2);
        add_row(op_amo_add, size_d, 0, 'h204, 64'h1, 31, 0, kind_trap, 6, 'h204, 0);
        add_row(op_load,  size_d, 0, 'h300, 0, 1, 0, kind_kill, 0, 0, 0);
        add_row(op_load,  size_d, 0, 'h300, 0, 2, 0, kind_wb, 64'hca55, 0, 0);
        add_row(op_load,  size_d, 0, 'h200, 0, 3, 0, kind_wb, 64'hffffffffffffff9c, 0, 0);
        // Pass-through, incoming cause and stalls.
        add_row(op_none, size_b, 0, 64'h123456789abcdef0, 0, 7, 0, kind_wb,
                64'h123456789abcdef0, 0, 0);
        add_row(op_none, size_b, 0, 'h999, 0, 4, 5, kind_trap, 5, 0, 1);
        add_row(op_none, size_b, 0, 'h1, 0, 8, 0, kind_kill, 0, 0, 0);
        add_row(op_load, size_d, 0, 'h100, 0, 9, 0, kind_wb, 64'hddeeff00bbccaa11, 0, 2);
        // Clear drops a store before MA acts on it.
        add_row(op_store, size_d, 0, 'h100, 64'h0, 0, 0, kind_clear, 0, 0, 0);
        add_row(op_load, size_d, 0, 'h100, 0, 10, 0, kind_wb, 64'hddeeff00bbccaa11, 0, 0);
        add_row(op_none, size_b, 0, 'h0, 0, 0, 0, kind_none, 0, 0, 0);  // Bubble.
    endtask

    // Cycle counter bounds the run.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            fail_run($sformatf("Timeout after %0d cycles with %0d results still pending",
                               cycles, expected.size()));
        end
    end

    // Scoreboard, checked on the falling edge.
    always @(negedge clk) begin
        row_t e;
        if (!reset && (wb_valid || trap_valid)) begin
            if (expected.size() == 0) begin
                fail_run($sformatf("Unexpected output at %0t with no result pending", $time));
            end
            e = expected.pop_front();
            if (e.kind == kind_wb) begin
                assert (wb_valid && !trap_valid) else
                    fail_run($sformatf("MISMATCH at %0t: pc %h expected write-back", $time, e.pc));
                assert (wb_rd == e.rd) else
                    fail_run($sformatf("MISMATCH at %0t: pc %h rd %0d, expected %0d",
                                       $time, e.pc, wb_rd, e.rd));
                assert (wb_data == e.exp) else
                    fail_run($sformatf("MISMATCH at %0t: pc %h data %h, expected %h",
                                       $time, e.pc, wb_data, e.exp));
            end else begin
                assert (trap_valid && !wb_valid) else
                    fail_run($sformatf("MISMATCH at %0t: pc %h expected trap", $time, e.pc));
                assert (trap_cause == e.exp[4:0] && trap_pc == e.pc) else
                    fail_run($sformatf("MISMATCH at %0t: trap cause %0d pc %h, expected %0d %h",
                                       $time, trap_cause, trap_pc, e.exp[4:0], e.pc));
                assert (trap_tval == e.tval) else
                    fail_run($sformatf("MISMATCH at %0t: pc %h tval %h, expected %h",
                                       $time, e.pc, trap_tval, e.tval));
            end
        end
    end

    initial begin
        int n;
        cycles = 0;
        limit  = 0;
        rng    = 32'h44b7;
        reset  = 1'b1;
        drive_idle(1'b0, 1'b0);
        build_table();
        limit = rows.size() * 4 + 50;
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        foreach (rows[i]) begin
            rng = xorshift(rng);
            n = rows[i].stalls + ((rng[2:0] == 3'd0) ? 1 : 0);
            repeat (n) begin
                drive_idle(1'b1, 1'b0);
                @(posedge clk);
                #2;
            end
            drive_row(rows[i]);
            if (rows[i].kind == kind_wb || rows[i].kind == kind_trap) begin
                expected.push_back(rows[i]);
            end
            @(posedge clk);
            #2;
            if (rows[i].kind == kind_clear) begin
                drive_idle(1'b1, 1'b1);  // MA stalls while the register flushes.
                @(posedge clk);
                #2;
            end
        end
        drive_idle(1'b0, 1'b0);
        repeat (3) @(posedge clk);  // Last result is due one edge after the final row.
        if (expected.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_run("Results still pending at end of run");
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
src/rv_mem_pkg.sv
src/stage_ex_ma.sv
src/mem_access.sv
src/data_ram.sv
src/mem_subsystem_top.sv
tb/mem_subsystem_assertions.sv
tb/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - src/rv_mem_pkg.sv
  - src/stage_ex_ma.sv
  - src/mem_access.sv
  - src/data_ram.sv
  - src/mem_subsystem_top.sv
  - target: simulation
    files:
      - tb/mem_subsystem_assertions.sv
      - tb/tb_mem_subsystem.sv
